// ==== hdl/graphics_pkg.sv ====
package graphics_pkg;

    // Command opcodes, first byte of every command
    typedef enum logic [7:0] {
        ASSIGN_COLOR = 8'h11,
        DRAW_SPRITE  = 8'h12,
        BUFFER_SHOW  = 8'h14
    } opcode_t;

    // Command decoder states
    typedef enum logic [2:0] {
        IDLE,
        COLOR_ARGS,
        SPRITE_ARGS,
        SPRITE_DATA,
        SKIP
    } decoder_state_t;

    // Visible area
    localparam int SCREEN_WIDTH  = 32;
    localparam int SCREEN_HEIGHT = 16;

    // Full raster including blanking
    localparam int LINE_TOTAL  = 40;
    localparam int FRAME_TOTAL = 20;

    // Sync placement, in columns and lines
    localparam int HSYNC_START  = 32;
    localparam int HSYNC_LENGTH = 4;
    localparam int VSYNC_START  = 16;
    localparam int VSYNC_LENGTH = 2;

    // Pixel address is row * 32 + column
    localparam int ADDRESS_WIDTH = 9;
    localparam int INDEX_WIDTH   = 4;

    // Y in 9:6, Cb in 5:3, Cr in 2:0
    localparam int COLOR_WIDTH = 10;

    // Counters to display outputs
    localparam int SCAN_LATENCY = 2;

endpackage

// ==== hdl/command_decoder.sv ====
`timescale 1ns/1ps

module command_decoder import graphics_pkg::*; (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic [7:0]             cmd_data,
    input  logic                   cmd_last,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    output logic                   sprite_start,
    output logic [7:0]             sprite_x,
    output logic [7:0]             sprite_y,
    output logic [5:0]             sprite_width,
    output logic [INDEX_WIDTH-1:0] sprite_offset,
    output logic [7:0]             sprite_data,
    output logic                   sprite_data_valid,
    input  logic                   sprite_data_ready,
    input  logic                   sprite_busy,
    output logic                   palette_write,
    output logic [INDEX_WIDTH-1:0] palette_index,
    output logic [COLOR_WIDTH-1:0] palette_color,
    output logic                   swap_request
);

    decoder_state_t   state;
    opcode_t          opcode;
    logic [1:0]       operand_count;
    logic             started;
    logic             transfer;
    logic [3:0]       color_y;

    assign opcode   = opcode_t'(cmd_data);
    assign transfer = cmd_valid && cmd_ready;

    // Sprite data bytes pass straight through to the engine
    assign sprite_data       = cmd_data;
    assign sprite_data_valid = cmd_valid && (state == SPRITE_DATA);

    always_comb begin
        case (state)
            // Hold new commands until pending pixel writes are done
            IDLE:        cmd_ready = started && !sprite_busy;
            SPRITE_DATA: cmd_ready = sprite_data_ready;
            default:     cmd_ready = 1'b1;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state         <= IDLE;
            operand_count <= '0;
            started       <= 1'b0;
            palette_write <= 1'b0;
            sprite_start  <= 1'b0;
            swap_request  <= 1'b0;
        end else begin
            started       <= 1'b1;
            palette_write <= 1'b0;
            sprite_start  <= 1'b0;
            swap_request  <= 1'b0;
            if (transfer) begin
                case (state)
                    IDLE: begin
                        operand_count <= '0;
                        case (opcode)
                            ASSIGN_COLOR: state <= cmd_last ? IDLE : COLOR_ARGS;
                            DRAW_SPRITE:  state <= cmd_last ? IDLE : SPRITE_ARGS;
                            BUFFER_SHOW: begin
                                swap_request <= 1'b1;
                                state        <= cmd_last ? IDLE : SKIP;
                            end
                            // Unknown opcode, discard the rest
                            default:      state <= cmd_last ? IDLE : SKIP;
                        endcase
                    end
                    COLOR_ARGS: begin
                        operand_count <= operand_count + 2'd1;
                        if (operand_count == 2'd2) begin
                            palette_write <= 1'b1;
                            state         <= cmd_last ? IDLE : SKIP;
                        end else if (cmd_last) begin
                            state <= IDLE;
                        end
                    end
                    SPRITE_ARGS: begin
                        operand_count <= operand_count + 2'd1;
                        if (operand_count == 2'd3) begin
                            sprite_start <= 1'b1;
                            state        <= cmd_last ? IDLE : SPRITE_DATA;
                        end else if (cmd_last) begin
                            state <= IDLE;
                        end
                    end
                    SPRITE_DATA, SKIP: begin
                        if (cmd_last) begin
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // Operand capture
    always_ff @(posedge clock) begin
        if (transfer && state == COLOR_ARGS) begin
            case (operand_count)
                2'd0:    palette_index <= cmd_data[3:0];
                2'd1:    color_y <= cmd_data[3:0];
                default: palette_color <= {color_y, cmd_data[5:0]};
            endcase
        end
        if (transfer && state == SPRITE_ARGS) begin
            case (operand_count)
                2'd0:    sprite_x <= cmd_data;
                2'd1:    sprite_y <= cmd_data;
                2'd2:    sprite_width <= cmd_data[5:0];
                default: sprite_offset <= cmd_data[3:0];
            endcase
        end
    end

endmodule

// ==== hdl/sprite_engine.sv ====
`timescale 1ns/1ps

module sprite_engine import graphics_pkg::*; (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     sprite_start,
    input  logic [7:0]               sprite_x,
    input  logic [7:0]               sprite_y,
    input  logic [5:0]               sprite_width,
    input  logic [INDEX_WIDTH-1:0]   sprite_offset,
    input  logic [7:0]               sprite_data,
    input  logic                     sprite_data_valid,
    output logic                     sprite_data_ready,
    output logic                     sprite_busy,
    output logic                     pixel_write,
    output logic [ADDRESS_WIDTH-1:0] pixel_address,
    output logic [INDEX_WIDTH-1:0]   pixel_index
);

    // High when the second pixel of a byte is being written
    logic       phase;
    logic [3:0] high_nibble;
    logic [4:0] column;
    logic [4:0] row;
    logic       accept;
    logic       emit;
    logic [3:0] nibble;
    logic [8:0] target_x;
    logic [8:0] target_y;

    assign sprite_data_ready = !phase && !sprite_start;
    assign sprite_busy       = phase;
    assign accept            = sprite_data_valid && sprite_data_ready;

    // Low nibble on the accepting cycle, high nibble on the next
    always_comb begin
        emit          = accept || phase;
        nibble        = phase ? high_nibble : sprite_data[3:0];
        target_x      = 9'(sprite_x) + 9'(column);
        target_y      = 9'(sprite_y) + 9'(row);
        pixel_index   = nibble + sprite_offset;
        pixel_address = {target_y[3:0], target_x[4:0]};
        // Zero is transparent, anything off screen is clipped
        pixel_write   = emit && (nibble != 4'd0) &&
                        (target_x < SCREEN_WIDTH) && (target_y < SCREEN_HEIGHT);
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            phase  <= 1'b0;
            column <= '0;
            row    <= '0;
        end else if (sprite_start) begin
            phase  <= 1'b0;
            column <= '0;
            row    <= '0;
        end else begin
            phase <= accept;
            if (emit) begin
                if ({1'b0, column} + 6'd1 == sprite_width) begin
                    column <= '0;
                    // Rows past the screen are all clipped, so stop counting there
                    if (row < 5'(SCREEN_HEIGHT)) begin
                        row <= row + 5'd1;
                    end
                end else begin
                    column <= column + 5'd1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            high_nibble <= sprite_data[7:4];
        end
    end

endmodule

// ==== hdl/frame_buffers.sv ====
`timescale 1ns/1ps

module frame_buffers import graphics_pkg::*; (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     pixel_write,
    input  logic [ADDRESS_WIDTH-1:0] pixel_address,
    input  logic [INDEX_WIDTH-1:0]   pixel_index,
    input  logic                     swap_request,
    input  logic                     frame_start,
    input  logic [ADDRESS_WIDTH-1:0] read_address,
    output logic [INDEX_WIDTH-1:0]   read_index
);

    logic [INDEX_WIDTH-1:0] frame_0 [2**ADDRESS_WIDTH];
    logic [INDEX_WIDTH-1:0] frame_1 [2**ADDRESS_WIDTH];
    logic                   front;
    logic                   swap_pending;
    logic                   display_select;
    logic                   write_select;

    // The read at frame start already sees the swapped front
    assign display_select = front ^ (frame_start && swap_pending);

    // Writes follow the back of the front-to-be
    assign write_select = ~(front ^ swap_pending);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            front        <= 1'b0;
            swap_pending <= 1'b0;
        end else if (frame_start) begin
            front        <= front ^ swap_pending;
            swap_pending <= swap_request;
        end else begin
            // Two shows in one frame cancel out
            swap_pending <= swap_pending ^ swap_request;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**ADDRESS_WIDTH; i++) begin
                frame_0[i] <= '0;
                frame_1[i] <= '0;
            end
        end else if (pixel_write) begin
            if (write_select) begin
                frame_1[pixel_address] <= pixel_index;
            end else begin
                frame_0[pixel_address] <= pixel_index;
            end
        end
    end

    always_ff @(posedge clock) begin
        read_index <= display_select ? frame_1[read_address] : frame_0[read_address];
    end

endmodule

// ==== hdl/color_palette.sv ====
`timescale 1ns/1ps

module color_palette import graphics_pkg::*; (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   palette_write,
    input  logic [INDEX_WIDTH-1:0] palette_index,
    input  logic [COLOR_WIDTH-1:0] palette_color,
    input  logic [INDEX_WIDTH-1:0] read_index,
    output logic [COLOR_WIDTH-1:0] lookup_color
);

    logic [COLOR_WIDTH-1:0] entries [2**INDEX_WIDTH];

    // Table starts out black
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**INDEX_WIDTH; i++) begin
                entries[i] <= '0;
            end
        end else if (palette_write) begin
            entries[palette_index] <= palette_color;
        end
    end

    // Lookup is one clock behind the index
    always_ff @(posedge clock) begin
        lookup_color <= entries[read_index];
    end

endmodule

// ==== hdl/display_scanner.sv ====
`timescale 1ns/1ps

module display_scanner import graphics_pkg::*; (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic [COLOR_WIDTH-1:0]   lookup_color,
    output logic [ADDRESS_WIDTH-1:0] read_address,
    output logic                     frame_start,
    output logic                     pixel_valid,
    output logic                     hsync,
    output logic                     vsync,
    output logic [3:0]               pixel_y,
    output logic [2:0]               pixel_cb,
    output logic [2:0]               pixel_cr
);

    logic [$clog2(LINE_TOTAL)-1:0]  column;
    logic [$clog2(FRAME_TOTAL)-1:0] line;
    logic                           visible;
    logic                           hsync_now;
    logic                           vsync_now;
    logic [SCAN_LATENCY-1:0]        valid_delay;
    logic [SCAN_LATENCY-1:0]        hsync_delay;
    logic [SCAN_LATENCY-1:0]        vsync_delay;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            column <= '0;
            line   <= '0;
        end else if (column == LINE_TOTAL - 1) begin
            column <= '0;
            line   <= (line == FRAME_TOTAL - 1) ? '0 : line + 1'b1;
        end else begin
            column <= column + 1'b1;
        end
    end

    always_comb begin
        visible      = (column < SCREEN_WIDTH) && (line < SCREEN_HEIGHT);
        hsync_now    = (column >= HSYNC_START) && (column < HSYNC_START + HSYNC_LENGTH);
        vsync_now    = (line >= VSYNC_START) && (line < VSYNC_START + VSYNC_LENGTH);
        frame_start  = (column == '0) && (line == '0);
        read_address = visible ? {line[3:0], column[4:0]} : '0;
    end

    // Match the buffer read plus the palette lookup
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_delay <= '0;
            hsync_delay <= '0;
            vsync_delay <= '0;
        end else begin
            valid_delay <= {valid_delay[SCAN_LATENCY-2:0], visible};
            hsync_delay <= {hsync_delay[SCAN_LATENCY-2:0], hsync_now};
            vsync_delay <= {vsync_delay[SCAN_LATENCY-2:0], vsync_now};
        end
    end

    assign pixel_valid = valid_delay[SCAN_LATENCY-1];
    assign hsync       = hsync_delay[SCAN_LATENCY-1];
    assign vsync       = vsync_delay[SCAN_LATENCY-1];

    // Blank outside the visible area
    assign pixel_y  = pixel_valid ? lookup_color[9:6] : '0;
    assign pixel_cb = pixel_valid ? lookup_color[5:3] : '0;
    assign pixel_cr = pixel_valid ? lookup_color[2:0] : '0;

endmodule

// ==== hdl/graphics.sv ====
`timescale 1ns/1ps

module graphics import graphics_pkg::*; (
    input  logic       clock,
    input  logic       arst_n,
    input  logic [7:0] cmd_data,
    input  logic       cmd_last,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    output logic       pixel_valid,
    output logic       hsync,
    output logic       vsync,
    output logic [3:0] pixel_y,
    output logic [2:0] pixel_cb,
    output logic [2:0] pixel_cr
);

    // Decoder to sprite engine
    logic                     sprite_start;
    logic [7:0]               sprite_x;
    logic [7:0]               sprite_y;
    logic [5:0]               sprite_width;
    logic [INDEX_WIDTH-1:0]   sprite_offset;
    logic [7:0]               sprite_data;
    logic                     sprite_data_valid;
    logic                     sprite_data_ready;
    logic                     sprite_busy;

    // Palette writes and buffer swap
    logic                     palette_write;
    logic [INDEX_WIDTH-1:0]   palette_index;
    logic [COLOR_WIDTH-1:0]   palette_color;
    logic                     swap_request;

    // Pixel writes into the back frame
    logic                     pixel_write;
    logic [ADDRESS_WIDTH-1:0] pixel_address;
    logic [INDEX_WIDTH-1:0]   pixel_index;

    // Scan-out path
    logic [ADDRESS_WIDTH-1:0] read_address;
    logic                     frame_start;
    logic [INDEX_WIDTH-1:0]   read_index;
    logic [COLOR_WIDTH-1:0]   lookup_color;

    command_decoder i_command_decoder (
        .clock(clock), .arst_n(arst_n),
        .cmd_data(cmd_data), .cmd_last(cmd_last),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .sprite_start(sprite_start), .sprite_x(sprite_x), .sprite_y(sprite_y),
        .sprite_width(sprite_width), .sprite_offset(sprite_offset),
        .sprite_data(sprite_data), .sprite_data_valid(sprite_data_valid),
        .sprite_data_ready(sprite_data_ready), .sprite_busy(sprite_busy),
        .palette_write(palette_write), .palette_index(palette_index),
        .palette_color(palette_color), .swap_request(swap_request)
    );

    sprite_engine i_sprite_engine (
        .clock(clock), .arst_n(arst_n),
        .sprite_start(sprite_start), .sprite_x(sprite_x), .sprite_y(sprite_y),
        .sprite_width(sprite_width), .sprite_offset(sprite_offset),
        .sprite_data(sprite_data), .sprite_data_valid(sprite_data_valid),
        .sprite_data_ready(sprite_data_ready), .sprite_busy(sprite_busy),
        .pixel_write(pixel_write), .pixel_address(pixel_address),
        .pixel_index(pixel_index)
    );

    frame_buffers i_frame_buffers (
        .clock(clock), .arst_n(arst_n),
        .pixel_write(pixel_write), .pixel_address(pixel_address),
        .pixel_index(pixel_index), .swap_request(swap_request),
        .frame_start(frame_start), .read_address(read_address),
        .read_index(read_index)
    );

    color_palette i_color_palette (
        .clock(clock), .arst_n(arst_n),
        .palette_write(palette_write), .palette_index(palette_index),
        .palette_color(palette_color), .read_index(read_index),
        .lookup_color(lookup_color)
    );

    display_scanner i_display_scanner (
        .clock(clock), .arst_n(arst_n),
        .lookup_color(lookup_color), .read_address(read_address),
        .frame_start(frame_start), .pixel_valid(pixel_valid),
        .hsync(hsync), .vsync(vsync),
        .pixel_y(pixel_y), .pixel_cb(pixel_cb), .pixel_cr(pixel_cr)
    );

endmodule

// ==== bench/graphics_props.sv ====
`timescale 1ns/1ps

module graphics_props (
    input logic       clock,
    input logic       arst_n,
    input logic [7:0] cmd_data,
    input logic       cmd_last,
    input logic       cmd_valid,
    input logic       cmd_ready,
    input logic       pixel_valid,
    input logic       hsync,
    input logic       vsync,
    input logic [3:0] pixel_y,
    input logic [2:0] pixel_cb,
    input logic [2:0] pixel_cr
);

    int         failure_count = 0;
    // Consecutive hsync cycles up to the previous edge
    logic [2:0] hsync_run;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            hsync_run <= '0;
        end else begin
            hsync_run <= hsync ? hsync_run + 3'd1 : 3'd0;
        end
    end

    stalled_byte_holds: assert property (@(posedge clock) disable iff (!arst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data) && $stable(cmd_last))
    else begin
        failure_count++;
        $error("command byte changed while stalled");
    end

    hsync_not_too_long: assert property (@(posedge clock) disable iff (!arst_n)
        hsync |-> hsync_run < 3'd4)
    else begin
        failure_count++;
        $error("hsync longer than 4 cycles");
    end

    hsync_not_too_short: assert property (@(posedge clock) disable iff (!arst_n)
        $fell(hsync) |-> hsync_run == 3'd4)
    else begin
        failure_count++;
        $error("hsync shorter than 4 cycles");
    end

    no_pixel_in_sync: assert property (@(posedge clock) disable iff (!arst_n)
        !(pixel_valid && (hsync || vsync)))
    else begin
        failure_count++;
        $error("pixel_valid high during sync");
    end

    blank_is_black: assert property (@(posedge clock) disable iff (!arst_n)
        !pixel_valid |-> {pixel_y, pixel_cb, pixel_cr} == '0)
    else begin
        failure_count++;
        $error("color outputs nonzero while pixel_valid is low");
    end

endmodule

bind graphics graphics_props i_graphics_props (
    .clock(clock), .arst_n(arst_n),
    .cmd_data(cmd_data), .cmd_last(cmd_last),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .pixel_valid(pixel_valid), .hsync(hsync), .vsync(vsync),
    .pixel_y(pixel_y), .pixel_cb(pixel_cb), .pixel_cr(pixel_cr)
);

// ==== bench/graphics_tb.sv ====
`timescale 1ns/1ps

module graphics_tb import graphics_pkg::*; ();

    localparam int BYTE_TIMEOUT = 200;
    localparam int FRAME_CYCLES = LINE_TOTAL * FRAME_TOTAL;
    localparam int PIXELS       = SCREEN_WIDTH * SCREEN_HEIGHT;

    logic       clock;
    logic       arst_n;
    logic [7:0] cmd_data;
    logic       cmd_last;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       pixel_valid;
    logic       hsync;
    logic       vsync;
    logic [3:0] pixel_y;
    logic [2:0] pixel_cb;
    logic [2:0] pixel_cr;

    logic [15:0]            lfsr;
    int                     errors;
    logic [COLOR_WIDTH-1:0] model_palette [16];
    logic [3:0]             model_frame [2][PIXELS];
    // Frame that the display shows once the pending swaps are applied
    logic                   model_front;
    logic [COLOR_WIDTH-1:0] captured [PIXELS];

    graphics i_dut (.*);

    initial clock = 1'b0;
    always #50 clock = ~clock;

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr     = {lfsr[14:0], feedback};
            value    = {value[30:0], feedback};
        end
        return value;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #10;
    endtask

    task automatic send_byte(input logic [7:0] data, input logic last);
        int   waited;
        logic accepted;
        // Random idle cycles ahead of the byte
        while (random_bits(2) == 0) begin
            cmd_valid = 1'b0;
            next_cycle();
        end
        cmd_data  = data;
        cmd_last  = last;
        cmd_valid = 1'b1;
        accepted  = 1'b0;
        waited    = 0;
        while (!accepted && waited < BYTE_TIMEOUT) begin
            #1;
            accepted = cmd_ready;
            next_cycle();
            waited++;
        end
        cmd_valid = 1'b0;
        assert (accepted) else begin
            errors++;
            $display("Timeout: cmd_ready stayed low for %0d cycles", BYTE_TIMEOUT);
        end
    endtask

    task automatic assign_color(input logic [3:0] index, input logic [COLOR_WIDTH-1:0] color);
        send_byte(ASSIGN_COLOR, 1'b0);
        send_byte({4'h0, index}, 1'b0);
        send_byte({4'h0, color[9:6]}, 1'b0);
        send_byte({2'b00, color[5:0]}, 1'b1);
        model_palette[index] = color;
    endtask

    task automatic show_buffer();
        send_byte(BUFFER_SHOW, 1'b1);
        model_front = ~model_front;
    endtask

    // Random sprite into the back frame with the model updated pixel by pixel
    task automatic draw_sprite();
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] data;
        logic [5:0] width;
        logic [3:0] offset;
        logic [3:0] nibble;
        int         bytes;
        int         column;
        int         row;
        x      = 8'(random_bits(5));
        y      = 8'(random_bits(4));
        width  = 6'(random_bits(5)) + 6'd1;
        offset = 4'(random_bits(4));
        bytes  = int'(random_bits(5)) + 1;
        send_byte(DRAW_SPRITE, 1'b0);
        send_byte(x, 1'b0);
        send_byte(y, 1'b0);
        send_byte({2'b00, width}, 1'b0);
        send_byte({4'h0, offset}, 1'b0);
        column = 0;
        row    = 0;
        for (int b = 0; b < bytes; b++) begin
            data = 8'(random_bits(8));
            // More transparent pixels than plain random data gives
            if (random_bits(2) == 0) begin
                data[3:0] = 4'h0;
            end
            for (int half = 0; half < 2; half++) begin
                nibble = (half == 1) ? data[7:4] : data[3:0];
                if (nibble != 4'h0 && x + column < SCREEN_WIDTH && y + row < SCREEN_HEIGHT) begin
                    model_frame[~model_front][(y + row) * SCREEN_WIDTH + x + column] =
                        nibble + offset;
                end
                column++;
                if (column == width) begin
                    column = 0;
                    row++;
                end
            end
            send_byte(data, b == bytes - 1);
        end
    endtask

    task automatic send_unknown();
        // Trailing bytes that look like opcodes must be skipped too
        send_byte(8'h5A, 1'b0);
        send_byte(BUFFER_SHOW, 1'b0);
        send_byte(DRAW_SPRITE, 1'b0);
        send_byte(ASSIGN_COLOR, 1'b1);
    endtask

    task automatic check_frame(input string name);
        int                     waited;
        int                     mismatches;
        int                     position;
        logic [COLOR_WIDTH-1:0] expected;
        // Wait for blanking so that the capture starts at row 0, column 0
        waited = 0;
        while (!vsync && waited < 2 * FRAME_CYCLES) begin
            next_cycle();
            waited++;
        end
        assert (vsync) else begin
            errors++;
            $display("Timeout: no vsync seen before %s", name);
        end
        waited = 0;
        while (!pixel_valid && waited < FRAME_CYCLES) begin
            next_cycle();
            waited++;
        end
        assert (pixel_valid) else begin
            errors++;
            $display("Timeout: no valid pixel seen before %s", name);
        end
        mismatches = 0;
        // 32 pixels and 4 clocks of hsync in every 40 clock line
        for (int cycle = 0; cycle < SCREEN_HEIGHT * LINE_TOTAL; cycle++) begin
            position = cycle % LINE_TOTAL;
            if (pixel_valid !== (position < SCREEN_WIDTH)) begin
                mismatches++;
            end
            if (hsync !== (position >= HSYNC_START && position < HSYNC_START + HSYNC_LENGTH)) begin
                mismatches++;
            end
            if (vsync !== 1'b0) begin
                mismatches++;
            end
            if (position < SCREEN_WIDTH) begin
                captured[(cycle / LINE_TOTAL) * SCREEN_WIDTH + position] =
                    {pixel_y, pixel_cb, pixel_cr};
            end
            next_cycle();
        end
        assert (mismatches == 0) else begin
            errors++;
            $display("[ERROR] %s timing: expected 0 mismatches, actual %0d", name, mismatches);
        end
        for (int a = 0; a < PIXELS; a++) begin
            expected = model_palette[model_frame[model_front][a]];
            assert (captured[a] == expected) else begin
                errors++;
                $display("[ERROR] %s pixel %0d: expected %h, actual %h",
                         name, a, expected, captured[a]);
            end
        end
    endtask

    initial begin
        lfsr        = 16'd59;
        errors      = 0;
        arst_n      = 1'b0;
        cmd_data    = '0;
        cmd_last    = 1'b0;
        cmd_valid   = 1'b0;
        model_front = 1'b0;
        for (int i = 0; i < 16; i++) begin
            model_palette[i] = '0;
        end
        for (int a = 0; a < PIXELS; a++) begin
            model_frame[0][a] = '0;
            model_frame[1][a] = '0;
        end
        repeat (16) @(posedge clock);
        #10;
        arst_n = 1'b1;

        check_frame("reset_frame");

        for (int i = 0; i < 16; i++) begin
            assign_color(4'(i), 10'(random_bits(10)));
        end
        draw_sprite();
        show_buffer();
        check_frame("palette_sprite");

        repeat (4) begin
            repeat (3) draw_sprite();
            show_buffer();
            check_frame("random_sprites");
        end

        // Drawing goes to the back frame only and the display keeps its content
        repeat (2) draw_sprite();
        check_frame("hidden_draw");
        show_buffer();
        check_frame("second_show");

        send_unknown();
        check_frame("unknown_opcode");

        // Index 0 covers the whole background
        assign_color(4'd0, ~model_palette[0]);
        check_frame("palette_change");

        $display("Checks finished: %0d errors, %0d property failures",
                 errors, i_dut.i_graphics_props.failure_count);
        if (errors == 0 && i_dut.i_graphics_props.failure_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/graphics_pkg.sv
hdl/command_decoder.sv
hdl/sprite_engine.sv
hdl/frame_buffers.sv
hdl/color_palette.sv
hdl/display_scanner.sv
hdl/graphics.sv
bench/graphics_props.sv
bench/graphics_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, the log decides the result
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module graphics_tb -f compile.f -o graphics_sim &&
    ./obj_dir/graphics_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
